/* Makefile */
# Verilator build and run for the burst memory controller testbench
VERILATOR ?= verilator
TOP       ?= tb_bmem_controller
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi; \
	echo "test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/beat_counter.sv */
// Two-bit index, so a burst is always exactly four beats long
`timescale 1ns/1ps

module beat_counter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clear,         // Start of a burst
    input  logic                                 beat_advance,  // Beat moved this cycle
    output logic [mem_burst_pkg::BEAT_IDX_W-1:0] beat_idx,
    output logic                                 last_beat
);

    logic wrapped;    // Set after beat 3 until the next burst start

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (clear) begin
            beat_idx <= '0;
        end else if (beat_advance) begin
            beat_idx <= beat_idx + 1'b1;     // Wraps back to 0 after the last beat
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrapped <= 1'b0;
        end else if (clear) begin
            wrapped <= 1'b0;
        end else if (last_beat) begin
            wrapped <= 1'b1;
        end
    end

    // Final beat being counted right now
    assign last_beat = beat_advance
                    && (beat_idx == mem_burst_pkg::BEAT_IDX_W'(mem_burst_pkg::BEATS_PER_LINE - 1));

    // No fifth beat inside one burst
    assert property (@(posedge clk) disable iff (!rst_n)
        (wrapped && !clear) |-> !beat_advance);

endmodule

/* design/bmem_controller.sv */
// One outstanding burst at a time; read beats must come back in order with no address tag
`timescale 1ns/1ps

module bmem_controller (
    input  logic                     clk,
    input  logic                     rst_n,

    input  mem_burst_pkg::line_req_t  icache_req,    // Instruction cache, reads only
    output mem_burst_pkg::line_resp_t icache_resp,
    input  mem_burst_pkg::line_req_t  dcache_req,    // Data cache, wins ties
    output mem_burst_pkg::line_resp_t dcache_resp,

    output mem_burst_pkg::addr_t     bmem_addr,
    output logic                     bmem_read,
    output logic                     bmem_write,
    output mem_burst_pkg::beat_t     bmem_wdata,
    input  logic                     bmem_ready,
    input  mem_burst_pkg::beat_t     bmem_rdata,
    input  logic                     bmem_rvalid
);

    // FSM to datapath
    logic                                 read_cmd;      // Burst launch strobe
    logic                                 beat_advance;  // One beat moved this cycle
    mem_burst_pkg::line_t                 wr_line;       // Latched write line
    logic                                 icache_resp_pulse;
    logic                                 dcache_resp_pulse;

    // Counter outputs
    logic [mem_burst_pkg::BEAT_IDX_W-1:0] beat_idx;
    logic                                 last_beat;

    mem_burst_pkg::line_t                 rd_line;       // Assembled read line

    burst_req_fsm fsm_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .icache_req        (icache_req),
        .dcache_req        (dcache_req),
        .bmem_ready        (bmem_ready),
        .bmem_rvalid       (bmem_rvalid),
        .last_beat         (last_beat),
        .bmem_addr         (bmem_addr),
        .bmem_read         (bmem_read),
        .bmem_write        (bmem_write),
        .read_cmd          (read_cmd),
        .beat_advance      (beat_advance),
        .wr_line           (wr_line),
        .icache_resp_pulse (icache_resp_pulse),
        .dcache_resp_pulse (dcache_resp_pulse)
    );

    beat_counter beat_cnt_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (read_cmd),       // Every burst starts at beat 0
        .beat_advance (beat_advance),
        .beat_idx     (beat_idx),
        .last_beat    (last_beat)
    );

    line_assembler line_asm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_we    (bmem_rvalid),      // Only the pending read returns beats
        .beat_idx   (beat_idx),
        .bmem_rdata (bmem_rdata),
        .rd_line    (rd_line)
    );

    write_beat_mux wr_mux_i (
        .wr_line    (wr_line),
        .beat_idx   (beat_idx),
        .bmem_wdata (bmem_wdata)
    );

    // Both ports see the same line, resp tells which one owns it
    assign icache_resp.resp  = icache_resp_pulse;
    assign icache_resp.rdata = rd_line;
    assign dcache_resp.resp  = dcache_resp_pulse;
    assign dcache_resp.rdata = rd_line;

endmodule

/* design/burst_req_fsm.sv */
// Data cache wins a tie; an icache write level is ignored; returns to IDLE after every resp
`timescale 1ns/1ps

module burst_req_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_burst_pkg::line_req_t icache_req,
    input  mem_burst_pkg::line_req_t dcache_req,
    input  logic                     bmem_ready,
    input  logic                     bmem_rvalid,
    input  logic                     last_beat,      // From the beat counter
    output mem_burst_pkg::addr_t     bmem_addr,
    output logic                     bmem_read,
    output logic                     bmem_write,
    output logic                     read_cmd,       // Burst launch that clears the counter
    output logic                     beat_advance,   // Counter step
    output mem_burst_pkg::line_t     wr_line,
    output logic                     icache_resp_pulse,
    output logic                     dcache_resp_pulse
);

    mem_burst_pkg::burst_state_t state, state_next;

    logic                 sel_dcache;    // Winner of the last arbitration
    logic                 is_write;      // Direction of the latched request
    mem_burst_pkg::addr_t req_addr;      // Latched line address
    logic                 write_active;
    logic                 respond;

    // Requests seen in IDLE
    logic dcache_want;
    logic icache_want;
    logic launch;

    assign dcache_want = dcache_req.read || dcache_req.write;
    assign icache_want = icache_req.read;                      // No icache writes

    // Reads wait for ready while writes go straight to the beat phase
    assign launch = (state == mem_burst_pkg::ISSUE) && (is_write || bmem_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= mem_burst_pkg::IDLE;
            sel_dcache <= 1'b0;
            is_write   <= 1'b0;
        end else begin
            state <= state_next;
            if (state == mem_burst_pkg::IDLE) begin
                if (dcache_want) begin
                    sel_dcache <= 1'b1;
                    is_write   <= dcache_req.write;    // Write takes precedence
                end else if (icache_want) begin
                    sel_dcache <= 1'b0;
                    is_write   <= 1'b0;
                end
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (state == mem_burst_pkg::IDLE) begin
            if (dcache_want) begin
                req_addr <= dcache_req.addr;
                wr_line  <= dcache_req.wdata;
            end else if (icache_want) begin
                req_addr <= icache_req.addr;
                wr_line  <= icache_req.wdata;     // Unused on a read
            end
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            mem_burst_pkg::IDLE: begin
                if (dcache_want || icache_want) state_next = mem_burst_pkg::ISSUE;
            end
            mem_burst_pkg::ISSUE: begin
                if (launch) begin
                    state_next = is_write ? mem_burst_pkg::WRITE_BEATS
                                          : mem_burst_pkg::READ_WAIT;
                end
            end
            mem_burst_pkg::READ_WAIT: begin
                if (last_beat) state_next = mem_burst_pkg::RESPOND;     // Fourth rvalid
            end
            mem_burst_pkg::WRITE_BEATS: begin
                if (last_beat) state_next = mem_burst_pkg::RESPOND;     // Fourth accepted beat
            end
            mem_burst_pkg::RESPOND: state_next = mem_burst_pkg::IDLE;
            default:                state_next = mem_burst_pkg::IDLE;
        endcase
    end

    assign write_active = (state == mem_burst_pkg::WRITE_BEATS);
    assign respond      = (state == mem_burst_pkg::RESPOND);

    // Memory command side
    assign bmem_addr  = req_addr;                 // Held through the whole write
    assign bmem_read  = launch && !is_write;      // Single cycle
    assign bmem_write = write_active;
    assign read_cmd   = launch;

    assign beat_advance = ((state == mem_burst_pkg::READ_WAIT) && bmem_rvalid)
                       || (write_active && bmem_ready);

    // Cache side pulses
    assign icache_resp_pulse = respond && !sel_dcache;
    assign dcache_resp_pulse = respond && sel_dcache;

    // Resp only reaches a port that still holds its request
    assert property (@(posedge clk) disable iff (!rst_n)
        dcache_resp_pulse |-> dcache_want);

    assert property (@(posedge clk) disable iff (!rst_n)
        icache_resp_pulse |-> icache_want);

    // Read command only into a ready memory and for a held read of the winner
    assert property (@(posedge clk) disable iff (!rst_n)
        bmem_read |-> (bmem_ready && (sel_dcache ? dcache_req.read : icache_req.read)));

    // Bursts only target whole lines
    assert property (@(posedge clk) disable iff (!rst_n)
        (state != mem_burst_pkg::IDLE)
            |-> (req_addr[mem_burst_pkg::LINE_OFFSET_W-1:0] == '0));

endmodule

/* design/line_assembler.sv */
// Beats land in order of the counter index; no check of the memory's read address
`timescale 1ns/1ps

module line_assembler (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 beat_we,     // Read beat arriving
    input  logic [mem_burst_pkg::BEAT_IDX_W-1:0] beat_idx,    // Slot for this beat
    input  mem_burst_pkg::beat_t                 bmem_rdata,
    output mem_burst_pkg::line_t                 rd_line
);

    // Beat k fills bits 64k upward, low beat first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_line <= '0;
        end else if (beat_we) begin
            rd_line[beat_idx*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W] <= bmem_rdata;
        end
    end
    // Holds after the last beat until the next read fills it again

endmodule

/* design/mem_burst_pkg.sv */
// Fixed 256-bit line over four 64-bit beats; line addresses are assumed 32-byte aligned
package mem_burst_pkg;

    // Memory side geometry
    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;    // One bus transfer
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;  // 256 bits
    localparam int BEAT_IDX_W     = 2;     // Indexes beats 0..3
    localparam int LINE_OFFSET_W  = 5;     // Byte offset inside a line

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [LINE_W-1:0] line_t;

    // Cache to controller, held as a level until resp
    typedef struct packed {
        addr_t addr;     // Line address
        logic  read;     // Read level
        logic  write;    // Write level, ignored on the icache port
        line_t wdata;    // Full line to store
    } line_req_t;

    // Controller to cache
    typedef struct packed {
        logic  resp;     // One-cycle completion pulse
        line_t rdata;    // Valid with resp on reads
    } line_resp_t;

    // Request FSM states
    typedef enum logic [2:0] {
        IDLE,            // Waiting for a cache request
        ISSUE,           // Launching the burst
        READ_WAIT,       // Collecting read beats
        WRITE_BEATS,     // Pushing write beats
        RESPOND          // Pulse resp to the winner
    } burst_state_t;

endpackage

/* design/write_beat_mux.sv */
// Combinational select; the beat changes only when the counter steps on an accepted beat
`timescale 1ns/1ps

module write_beat_mux (
    input  mem_burst_pkg::line_t                 wr_line,    // Latched write line
    input  logic [mem_burst_pkg::BEAT_IDX_W-1:0] beat_idx,   // Current beat
    output mem_burst_pkg::beat_t                 bmem_wdata
);

    // Same ordering as the assembler, beat 0 is bits 63:0
    always_comb begin
        unique case (beat_idx)
            2'd0:    bmem_wdata = wr_line[0*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W];
            2'd1:    bmem_wdata = wr_line[1*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W];
            2'd2:    bmem_wdata = wr_line[2*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W];
            default: bmem_wdata = wr_line[3*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W];
        endcase
    end
    // Stalled cycles keep the index, so the beat repeats

endmodule

/* verif/bmem_patterns.txt */
# Burst controller requests, one per line, issued in file order
# Columns: port (I or D), op (R or W), pair (1 = starts with the next line),
#          line address (hex), 256-bit line (hex, beat 3 first, beat 0 last)
# Read lines not written earlier are the memory preload and the expected data
I R 0 00001000 01305A5AC3C3013F01205A5AC3C3012F01105A5AC3C3011F01005A5AC3C3010F
I R 0 00001020 02305A5AC3C3023F02205A5AC3C3022F02105A5AC3C3021F02005A5AC3C3020F
D R 0 00002000 03305A5AC3C3033F03205A5AC3C3032F03105A5AC3C3031F03005A5AC3C3030F
# Write then read back on both ports
D W 0 00003000 0430E1E1B7B7043F0420E1E1B7B7042F0410E1E1B7B7041F0400E1E1B7B7040F
D R 0 00003000 0430E1E1B7B7043F0420E1E1B7B7042F0410E1E1B7B7041F0400E1E1B7B7040F
I R 0 00003000 0430E1E1B7B7043F0420E1E1B7B7042F0410E1E1B7B7041F0400E1E1B7B7040F
# Overwrite a preloaded line
D W 0 00001000 0530E1E1B7B7053F0520E1E1B7B7052F0510E1E1B7B7051F0500E1E1B7B7050F
D R 0 00001000 0530E1E1B7B7053F0520E1E1B7B7052F0510E1E1B7B7051F0500E1E1B7B7050F
# Both ports in one cycle, dcache first
D R 1 00002040 06305A5AC3C3063F06205A5AC3C3062F06105A5AC3C3061F06005A5AC3C3060F
I R 0 00001040 07305A5AC3C3073F07205A5AC3C3072F07105A5AC3C3071F07005A5AC3C3070F
D W 1 00004000 0830E1E1B7B7083F0820E1E1B7B7082F0810E1E1B7B7081F0800E1E1B7B7080F
I R 0 00001020 02305A5AC3C3023F02205A5AC3C3022F02105A5AC3C3021F02005A5AC3C3020F
D R 0 00004000 0830E1E1B7B7083F0820E1E1B7B7082F0810E1E1B7B7081F0800E1E1B7B7080F
# High and top-of-range addresses
I R 0 80000000 09305A5AC3C3093F09205A5AC3C3092F09105A5AC3C3091F09005A5AC3C3090F
D W 0 FFFFFFE0 0A30E1E1B7B70A3F0A20E1E1B7B70A2F0A10E1E1B7B70A1F0A00E1E1B7B70A0F
D R 0 FFFFFFE0 0A30E1E1B7B70A3F0A20E1E1B7B70A2F0A10E1E1B7B70A1F0A00E1E1B7B70A0F
I R 0 7FFFFFE0 0B305A5AC3C30B3F0B205A5AC3C30B2F0B105A5AC3C30B1F0B005A5AC3C30B0F
D R 1 80000000 09305A5AC3C3093F09205A5AC3C3092F09105A5AC3C3091F09005A5AC3C3090F
I R 0 00002000 03305A5AC3C3033F03205A5AC3C3032F03105A5AC3C3031F03005A5AC3C3030F
# Second write to one address
D W 0 00003000 0C30E1E1B7B70C3F0C20E1E1B7B70C2F0C10E1E1B7B70C1F0C00E1E1B7B70C0F
I R 0 00003000 0C30E1E1B7B70C3F0C20E1E1B7B70C2F0C10E1E1B7B70C1F0C00E1E1B7B70C0F
D R 0 7FFFFFE0 0B305A5AC3C30B3F0B205A5AC3C30B2F0B105A5AC3C30B1F0B005A5AC3C30B0F

/* verif/tb_bmem_controller.sv */
// Run from the project root; every read in the pattern file must hit a preloaded or earlier-written line
`timescale 1ns/1ps

module tb_bmem_controller;

    localparam int MAX_PAT = 64;    // Pattern table depth

    logic                       clk = 1'b0;
    logic                       rst_n;
    mem_burst_pkg::line_req_t   icache_req;
    mem_burst_pkg::line_resp_t  icache_resp;
    mem_burst_pkg::line_req_t   dcache_req;
    mem_burst_pkg::line_resp_t  dcache_resp;
    mem_burst_pkg::addr_t       bmem_addr;
    logic                       bmem_read;
    logic                       bmem_write;
    mem_burst_pkg::beat_t       bmem_wdata;
    logic                       bmem_ready;
    mem_burst_pkg::beat_t       bmem_rdata;
    logic                       bmem_rvalid;

    // Pattern table, filled from the data file
    logic [7:0]                 pat_port [MAX_PAT];    // I or D
    logic [7:0]                 pat_op   [MAX_PAT];    // R or W
    bit                         pat_pair [MAX_PAT];    // Shares its start cycle with the next entry
    mem_burst_pkg::addr_t       pat_addr [MAX_PAT];
    mem_burst_pkg::line_t       pat_line [MAX_PAT];
    int                         n_pat = 0;
    bit                         loaded = 1'b0;

    // Memory model state
    mem_burst_pkg::line_t       mem_model [mem_burst_pkg::addr_t];
    bit                         written_addr [mem_burst_pkg::addr_t];   // Written earlier in the file
    int                         seed = 40882;
    mem_burst_pkg::addr_t       rd_addr;
    int                         rd_left = 0;     // Beats still owed
    int                         rd_beat = 0;
    int                         rd_wait = 0;     // Idle cycles before the next beat
    int                         wr_beat = 0;     // Beats accepted in this write
    logic                       prev_read = 1'b0;
    logic                       prev_write = 1'b0;

    bit                         i_active = 1'b0; // Request held on the port
    bit                         d_active = 1'b0;
    int                         errors = 0;
    int                         checks = 0;
    int                         idx;

    bmem_controller dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .icache_req  (icache_req),
        .icache_resp (icache_resp),
        .dcache_req  (dcache_req),
        .dcache_resp (dcache_resp),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    always #10 clk = ~clk;    // 20 ns period

    task automatic report_error(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_line(input string name, input mem_burst_pkg::line_t expected,
                              input mem_burst_pkg::line_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input mem_burst_pkg::beat_t expected,
                              input mem_burst_pkg::beat_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic string test_name(input int n);
        return $sformatf("pattern%0d_%s%s", n, pat_port[n], pat_op[n]);
    endfunction

    // Reads the table; read lines not written earlier become the memory preload
    task automatic load_patterns();
        int                   fd;
        int                   code;
        int                   n;
        int                   pair_v;
        string                text;
        logic [7:0]           port_c;
        logic [7:0]           op_c;
        mem_burst_pkg::addr_t addr_v;
        mem_burst_pkg::line_t line_v;
        fd = $fopen("verif/bmem_patterns.txt", "r");
        if (fd == 0) begin
            report_error("cannot open verif/bmem_patterns.txt");
        end else begin
            while (!$feof(fd) && n_pat < MAX_PAT) begin
                code = $fgets(text, fd);
                if (code > 0 && text.getc(0) != "#") begin      // Skip comment lines
                    n = $sscanf(text, "%s %s %d %h %h", port_c, op_c, pair_v, addr_v, line_v);
                    if (n == 5) begin
                        pat_port[n_pat] = port_c;
                        pat_op[n_pat]   = op_c;
                        pat_pair[n_pat] = (pair_v != 0);
                        pat_addr[n_pat] = addr_v;
                        pat_line[n_pat] = line_v;
                        if (op_c == "W") written_addr[addr_v] = 1'b1;
                        else if (!written_addr.exists(addr_v) && !mem_model.exists(addr_v))
                            mem_model[addr_v] = line_v;
                        n_pat++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_pat == 0) report_error("no patterns found in the data file");
    endtask

    // Memory side, sampled mid-cycle where the DUT outputs are settled
    task automatic sample_bus();
        mem_burst_pkg::line_t tmp;
        if (rst_n) begin
            if (bmem_read) begin
                if (!bmem_ready) report_error("read command while bmem_ready low");
                if (prev_read) report_error("read command held longer than one cycle");
                if (rd_left != 0) report_error("read command during an unfinished burst");
                if (!mem_model.exists(bmem_addr)) report_error("read of an address with no line");
                rd_addr = bmem_addr;
                rd_left = mem_burst_pkg::BEATS_PER_LINE;
                rd_beat = 0;
                rd_wait = 2 + $unsigned($random(seed)) % 7;    // 2 to 8 cycles
            end
            if (bmem_write && bmem_ready) begin
                if (!mem_model.exists(bmem_addr)) mem_model[bmem_addr] = '0;
                tmp = mem_model[bmem_addr];
                if (wr_beat < mem_burst_pkg::BEATS_PER_LINE)
                    tmp[wr_beat*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W] = bmem_wdata;
                else
                    report_error("more than four write beats in one burst");
                mem_model[bmem_addr] = tmp;
                wr_beat++;
            end
            if (prev_write && !bmem_write) begin    // Write burst just ended
                if (wr_beat != mem_burst_pkg::BEATS_PER_LINE)
                    report_error($sformatf("write burst ended after %0d beats", wr_beat));
                wr_beat = 0;
            end
            if (icache_resp.resp && !i_active) report_error("icache resp without a request");
            if (dcache_resp.resp && !d_active) report_error("dcache resp without a request");
            if (icache_resp.resp && dcache_resp.resp)
                report_error("icache and dcache resp in the same cycle");
        end
        prev_read  = bmem_read;
        prev_write = bmem_write;
    endtask

    task automatic drive_bus();
        mem_burst_pkg::line_t tmp;
        bmem_ready  = (($random(seed) & 3) != 0);    // Low about a quarter of the time
        bmem_rvalid = 1'b0;
        if (rd_left > 0) begin
            if (rd_wait > 0) begin
                rd_wait--;
            end else begin
                tmp         = mem_model.exists(rd_addr) ? mem_model[rd_addr] : '0;
                bmem_rvalid = 1'b1;
                bmem_rdata  = tmp[rd_beat*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W];
                rd_beat++;
                rd_left--;
                rd_wait = $unsigned($random(seed)) % 3;    // Gap before the next beat
            end
        end
    endtask

    initial begin
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        forever begin
            @(negedge clk);
            sample_bus();
            @(posedge clk);
            #2;
            drive_bus();
        end
    end

    // Read lines come from the file, written lines from the model
    task automatic check_result(input int n, input mem_burst_pkg::line_t rdata);
        mem_burst_pkg::line_t stored;
        if (pat_op[n] == "R") begin
            check_line(test_name(n), pat_line[n], rdata);
        end else if (!mem_model.exists(pat_addr[n])) begin
            report_error($sformatf("%s left no line in memory", test_name(n)));
        end else begin
            stored = mem_model[pat_addr[n]];
            for (int k = 0; k < mem_burst_pkg::BEATS_PER_LINE; k++) begin
                check_beat($sformatf("%s_beat%0d", test_name(n), k),
                           pat_line[n][k*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W],
                           stored[k*mem_burst_pkg::BEAT_W +: mem_burst_pkg::BEAT_W]);
            end
        end
    endtask

    // Raises one or two requests together and holds each until its resp
    task automatic serve_requests(input int first, input int count);
        int   n;
        int   i_idx;
        int   d_idx;
        logic got_i;
        logic got_d;
        i_idx = -1;
        d_idx = -1;
        @(posedge clk);
        #2;
        for (int k = 0; k < count; k++) begin
            n = first + k;
            if (pat_port[n] == "D") begin
                d_idx            = n;
                dcache_req.addr  = pat_addr[n];
                dcache_req.read  = (pat_op[n] == "R");
                dcache_req.write = (pat_op[n] == "W");
                dcache_req.wdata = pat_line[n];
                d_active         = 1'b1;
            end else begin
                i_idx            = n;
                icache_req.addr  = pat_addr[n];
                icache_req.read  = 1'b1;     // Icache only reads
                icache_req.write = 1'b0;
                icache_req.wdata = '0;
                i_active         = 1'b1;
            end
        end
        while (i_active || d_active) begin
            @(negedge clk);
            got_i = i_active && icache_resp.resp;
            got_d = d_active && dcache_resp.resp;
            if (got_d) check_result(d_idx, dcache_resp.rdata);
            if (got_i) begin
                if (d_active && !got_d) report_error("icache served before the waiting dcache");
                check_result(i_idx, icache_resp.rdata);
            end
            if (got_i || got_d) begin
                @(posedge clk);
                #2;                          // Drop in the cycle after the pulse
                if (got_i) begin
                    icache_req = '0;
                    i_active   = 1'b0;
                end
                if (got_d) begin
                    dcache_req = '0;
                    d_active   = 1'b0;
                end
            end
        end
    endtask

    initial begin
        wait (loaded);
        repeat (n_pat * 200 + 20) @(posedge clk);
        $display("watchdog expired after %0d cycles with requests still open", n_pat * 200 + 20);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        load_patterns();
        loaded = 1'b1;
        repeat (9) @(posedge clk);
        @(negedge clk);
        if ({bmem_read, bmem_write, icache_resp.resp, dcache_resp.resp} !== 4'b0)
            report_error("command or resp signal high during reset");
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        idx   = 0;
        while (idx < n_pat) begin
            if (pat_pair[idx] && idx + 1 < n_pat) begin
                serve_requests(idx, 2);
                idx += 2;
            end else begin
                serve_requests(idx, 1);
                idx += 1;
            end
        end
        repeat (4) @(posedge clk);    // Catch late stray pulses
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* vlog.f */
design/mem_burst_pkg.sv
design/beat_counter.sv
design/line_assembler.sv
design/write_beat_mux.sv
design/burst_req_fsm.sv
design/bmem_controller.sv
verif/tb_bmem_controller.sv
